//--- verilog.f
verilog/fpu_pkg.sv
verilog/operand_forward.sv
verilog/issue_stage.sv
verilog/exec_stage.sv
verilog/fpu_port.sv
sim/fpu_port_props.sv
sim/tb_fpu_port.sv

//--- Bender.yml
package:
  name: fpu_port

sources:
  - files:
      - verilog/fpu_pkg.sv
      - verilog/operand_forward.sv
      - verilog/issue_stage.sv
      - verilog/exec_stage.sv
      - verilog/fpu_port.sv
  - target: simulation
    files:
      - sim/fpu_port_props.sv
      - sim/tb_fpu_port.sv

//--- sim/tb_fpu_port.sv
// fpu port testbench with bus model, reference model and retire checker
`default_nettype none
`timescale 1ns/1ps

module tb_fpu_port;

  localparam int CLK_PERIOD = 8;
  localparam int N_DIRECTED = 24;
  localparam int N_RANDOM   = 300;
  localparam int N_TESTS    = N_DIRECTED + N_RANDOM;

  logic               clk;
  logic               rst;
  logic               en;
  fpu_pkg::opcode_t   op;
  fpu_pkg::bus_word_t a_reg;
  fpu_pkg::bus_word_t b_reg;
  logic               a_fwd;
  logic               b_fwd;
  fpu_pkg::bus_idx_t  a_bus;
  fpu_pkg::bus_idx_t  b_bus;
  logic               a_late;
  logic               b_late;
  fpu_pkg::bus_word_t ext_bus [3];
  fpu_pkg::bus_word_t result;
  logic               result_valid;
  fpu_pkg::ret_code_t ret;
  logic               ret_en;

  // bus model, current cycle and one cycle back
  fpu_pkg::bus_word_t bus_cur [4];
  fpu_pkg::bus_word_t bus_prev [4];
  fpu_pkg::bus_word_t bus0;
  // {ret code, result word} per issued op
  logic [70:0]        exp_q [$];
  logic [15:0]        lfsr_state = 16'd10337;

  fpu_port u_dut (
    .clk(clk), .rst(rst), .en(en), .op(op), .a_reg(a_reg), .b_reg(b_reg),
    .a_fwd(a_fwd), .b_fwd(b_fwd), .a_bus(a_bus), .b_bus(b_bus), .a_late(a_late),
    .b_late(b_late), .ext_bus(ext_bus), .result(result), .result_valid(result_valid),
    .ret(ret), .ret_en(ret_en)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hb400;
    end
    return out;
  endfunction

  function automatic logic [67:0] take_bits(input int n);
    logic [67:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[66:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic fpu_pkg::bus_word_t make_word(input logic [67:0] d, input logic flip);
    return {(^d) ^ flip, d};
  endfunction

  function automatic fpu_pkg::bus_word_t resolve(input logic fwd, input logic [1:0] sel,
                                                 input logic late, input fpu_pkg::bus_word_t w);
    if (!fwd) begin
      return w;
    end else if (late) begin
      return bus_prev[sel];
    end
    return bus_cur[sel];
  endfunction

  // expected {ret code, result word} for one op
  function automatic logic [70:0] expect_result(input logic [3:0] opc,
                                                input fpu_pkg::bus_word_t a,
                                                input fpu_pkg::bus_word_t b);
    logic [67:0] ad;
    logic [67:0] bd;
    logic [67:0] d;
    logic [1:0]  code;
    ad = a[67:0];
    bd = b[67:0];
    d = '0;
    code = fpu_pkg::RET_OK;
    if ((^a) || (^b)) begin
      code = fpu_pkg::RET_PARITY;
    end else if (opc > 4'd7) begin
      code = fpu_pkg::RET_ILLEGAL;
    end else begin
      case (opc)
        4'd0:    d = ad & bd;
        4'd1:    d = ad | bd;
        4'd2:    d = ad ^ bd;
        4'd3:    d = ad & ~bd;
        4'd4:    d = ad;
        4'd5:    d = bd;
        4'd6:    d = {ad[67:64], ad[31:0], ad[63:32]};
        default: d = {ad[67:64], ad[31:0], ad[31:0]};
      endcase
    end
    return {code, ^d, d};
  endfunction

  task automatic stop_on_failure();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [68:0] exp, input logic [68:0] act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  // mixed adds idle cycles, reserved opcodes and bad parity
  task automatic pick_random_inputs(input logic mixed);
    logic [3:0] opc;
    opc = 4'(take_bits(3));
    opc[3] = (take_bits(3) == '0) & mixed;
    en <= (take_bits(3) != '0) | !mixed;
    op <= fpu_pkg::opcode_t'(opc);
    a_reg <= make_word(take_bits(68), (take_bits(4) == '0) & mixed);
    b_reg <= make_word(take_bits(68), (take_bits(4) == '0) & mixed);
    a_fwd <= 1'(take_bits(1));
    b_fwd <= 1'(take_bits(1));
    a_bus <= 2'(take_bits(2));
    b_bus <= 2'(take_bits(2));
    a_late <= 1'(take_bits(1));
    b_late <= 1'(take_bits(1));
    for (int i = 0; i < 3; i++) begin
      ext_bus[i] <= make_word(take_bits(68), (take_bits(5) == '0) & mixed);
    end
  endtask

  // model and compare, inputs and outputs are stable at the falling edge
  initial begin
    logic               pipe_v [2];
    logic [70:0]        pipe_e [2];
    logic [70:0]        entry;
    fpu_pkg::bus_word_t a_op;
    fpu_pkg::bus_word_t b_op;
    pipe_v[0] = 1'b0;
    pipe_v[1] = 1'b0;
    bus0 = '0;
    for (int i = 0; i < 4; i++) begin
      bus_prev[i] = '0;
    end
    wait (rst === 1'b0);
    forever begin
      @(negedge clk);
      // op seen two cycles ago has retired at the last edge
      if (pipe_v[1] && pipe_e[1][70:69] == 2'(fpu_pkg::RET_OK)) begin
        bus0 = pipe_e[1][68:0];
      end
      pipe_v[1] = pipe_v[0];
      pipe_e[1] = pipe_e[0];
      if (ret_en) begin
        if (exp_q.size() == 0) begin
          $display("ret_en went high at %0t with no op in flight", $time);
          stop_on_failure();
        end else begin
          entry = exp_q.pop_front();
          check_val("ret", 69'(entry[70:69]), 69'(ret));
          check_val("result_valid", 69'(entry[70:69] == 2'(fpu_pkg::RET_OK)),
                    69'(result_valid));
          check_val("result", bus0, result);
        end
      end else begin
        check_val("result_valid", '0, 69'(result_valid));
      end
      bus_cur[0] = bus0;
      for (int i = 1; i < 4; i++) begin
        bus_cur[i] = ext_bus[i-1];
      end
      a_op = resolve(a_fwd, a_bus, a_late, a_reg);
      b_op = resolve(b_fwd, b_bus, b_late, b_reg);
      entry = expect_result(4'(op), a_op, b_op);
      if (en) begin
        exp_q.push_back(entry);
      end
      pipe_v[0] = en;
      pipe_e[0] = entry;
      bus_prev = bus_cur;
    end
  end

  initial begin
    #((N_TESTS + 20) * CLK_PERIOD);
    $display("timeout, the run did not finish in %0d cycles", N_TESTS + 20);
    stop_on_failure();
  end

  initial begin
    rst = 1'b1;
    en = 1'b0;
    op = fpu_pkg::OP_AND;
    a_reg = '0;
    b_reg = '0;
    a_fwd = 1'b0;
    b_fwd = 1'b0;
    a_bus = '0;
    b_bus = '0;
    a_late = 1'b0;
    b_late = 1'b0;
    for (int i = 0; i < 3; i++) begin
      ext_bus[i] = '0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_val("result", '0, result);
    check_val("ret_en", '0, 69'(ret_en));
    // every function from register-file operands
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      pick_random_inputs(1'b0);
      op <= fpu_pkg::opcode_t'(4'(i));
      a_fwd <= 1'b0;
      b_fwd <= 1'b0;
    end
    // bad parity on a, then on b
    @(posedge clk);
    pick_random_inputs(1'b0);
    a_reg <= make_word(take_bits(68), 1'b1);
    a_fwd <= 1'b0;
    @(posedge clk);
    pick_random_inputs(1'b0);
    op <= fpu_pkg::OP_COPY_A;
    b_reg <= make_word(take_bits(68), 1'b1);
    b_fwd <= 1'b0;
    // reserved opcode alone, then together with bad parity
    @(posedge clk);
    pick_random_inputs(1'b0);
    op <= fpu_pkg::opcode_t'(4'd9);
    @(posedge clk);
    pick_random_inputs(1'b0);
    op <= fpu_pkg::opcode_t'(4'd12);
    a_reg <= make_word(take_bits(68), 1'b1);
    a_fwd <= 1'b0;
    // dependent chain on the own result bus
    for (int i = 0; i < 12; i++) begin
      @(posedge clk);
      pick_random_inputs(1'b0);
      a_fwd <= 1'b1;
      a_bus <= '0;
    end
    for (int i = 0; i < N_RANDOM; i++) begin
      @(posedge clk);
      pick_random_inputs(1'b1);
    end
    @(posedge clk);
    en <= 1'b0;
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d issued ops never retired", exp_q.size());
      stop_on_failure();
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sim/fpu_port_props.sv
// fpu port assertions on retire timing and result parity, bound to the top level
`default_nettype none
`timescale 1ns/1ps

module fpu_port_props (
  input logic               clk,
  input logic               rst,
  input logic               en,
  input fpu_pkg::bus_word_t result,
  input logic               result_valid,
  input fpu_pkg::ret_code_t ret,
  input logic               ret_en
);

  // every issue retires two edges later
  a_issue_retires: assert property (@(posedge clk) disable iff (rst) en |-> ##2 ret_en)
    else $error("issued op did not retire two cycles later");

  a_valid_is_ok: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> (ret_en && ret == fpu_pkg::RET_OK))
    else $error("result_valid without a good retire");

  a_result_parity: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> (result[fpu_pkg::DATA_W] == ^result[fpu_pkg::DATA_W-1:0]))
    else $error("result parity bit does not match its data");

endmodule

bind fpu_port fpu_port_props u_props (
  .clk(clk), .rst(rst), .en(en), .result(result), .result_valid(result_valid),
  .ret(ret), .ret_en(ret_en)
);

`default_nettype wire

//--- verilog/fpu_port.sv
// fpu issue port top joining operand forwarding, issue and execute with result loopback
`default_nettype none
`timescale 1ns/1ps

module fpu_port (
  input  logic               clk,
  input  logic               rst,
  input  logic               en,
  input  fpu_pkg::opcode_t   op,
  input  fpu_pkg::bus_word_t a_reg,
  input  fpu_pkg::bus_word_t b_reg,
  input  logic               a_fwd,
  input  logic               b_fwd,
  input  fpu_pkg::bus_idx_t  a_bus,
  input  fpu_pkg::bus_idx_t  b_bus,
  input  logic               a_late,
  input  logic               b_late,
  // ext_bus[i] is result bus i+1
  input  fpu_pkg::bus_word_t ext_bus [fpu_pkg::BUS_COUNT-1],
  output fpu_pkg::bus_word_t result,
  output logic               result_valid,
  output fpu_pkg::ret_code_t ret,
  output logic               ret_en
);

  fpu_pkg::bus_word_t  buses [fpu_pkg::BUS_COUNT];
  fpu_pkg::bus_word_t  a_word;
  fpu_pkg::bus_word_t  b_word;
  logic                iss_valid;
  fpu_pkg::data_t      iss_a_data;
  fpu_pkg::data_t      iss_b_data;
  logic                iss_is_logic;
  fpu_pkg::logic_sel_t iss_logic_sel;
  fpu_pkg::perm_sel_t  iss_perm_sel;
  fpu_pkg::ret_code_t  iss_code;

  // own result loops back as bus 0
  assign buses[0] = result;

  for (genvar i = 1; i < fpu_pkg::BUS_COUNT; i++) begin : g_ext
    assign buses[i] = ext_bus[i-1];
  end

  operand_forward u_fwd_a (
    .clk(clk), .reg_word(a_reg), .fwd(a_fwd), .bus_sel(a_bus), .late(a_late),
    .buses(buses), .operand(a_word)
  );

  operand_forward u_fwd_b (
    .clk(clk), .reg_word(b_reg), .fwd(b_fwd), .bus_sel(b_bus), .late(b_late),
    .buses(buses), .operand(b_word)
  );

  issue_stage u_issue (
    .clk(clk), .rst(rst), .en(en), .op(op), .a_word(a_word), .b_word(b_word),
    .valid(iss_valid), .a_data(iss_a_data), .b_data(iss_b_data),
    .is_logic(iss_is_logic), .logic_sel(iss_logic_sel), .perm_sel(iss_perm_sel),
    .code(iss_code)
  );

  exec_stage u_exec (
    .clk(clk), .rst(rst), .valid(iss_valid), .a_data(iss_a_data), .b_data(iss_b_data),
    .is_logic(iss_is_logic), .logic_sel(iss_logic_sel), .perm_sel(iss_perm_sel),
    .code(iss_code), .result(result), .result_valid(result_valid), .ret(ret),
    .ret_en(ret_en)
  );

endmodule

`default_nettype wire

//--- verilog/exec_stage.sv
// execute stage running logic and permute ops, packing the result bus word and retire code
`default_nettype none
`timescale 1ns/1ps

module exec_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                valid,
  input  fpu_pkg::data_t      a_data,
  input  fpu_pkg::data_t      b_data,
  input  logic                is_logic,
  input  fpu_pkg::logic_sel_t logic_sel,
  input  fpu_pkg::perm_sel_t  perm_sel,
  input  fpu_pkg::ret_code_t  code,
  output fpu_pkg::bus_word_t  result,
  output logic                result_valid,
  output fpu_pkg::ret_code_t  ret,
  output logic                ret_en
);

  localparam int SW = fpu_pkg::SINGLE_W;
  localparam int DW = fpu_pkg::DATA_W;

  fpu_pkg::data_t     logic_res;
  fpu_pkg::data_t     perm_res;
  fpu_pkg::data_t     res_data;
  fpu_pkg::bus_word_t res_word;
  logic               write_res;

  always_comb begin
    case (logic_sel)
      fpu_pkg::LOGIC_AND:  logic_res = a_data & b_data;
      fpu_pkg::LOGIC_OR:   logic_res = a_data | b_data;
      fpu_pkg::LOGIC_XOR:  logic_res = a_data ^ b_data;
      default:             logic_res = a_data & ~b_data;
    endcase
  end

  // swap and dup keep the class bits of A
  always_comb begin
    case (perm_sel)
      fpu_pkg::PERM_COPY_A: perm_res = a_data;
      fpu_pkg::PERM_COPY_B: perm_res = b_data;
      fpu_pkg::PERM_SWAP: begin
        perm_res = {a_data[DW-1:2*SW], a_data[SW-1:0], a_data[2*SW-1:SW]};
      end
      default: begin
        perm_res = {a_data[DW-1:2*SW], a_data[SW-1:0], a_data[SW-1:0]};
      end
    endcase
  end

  assign res_data  = is_logic ? logic_res : perm_res;
  assign res_word  = {^res_data, res_data};
  assign write_res = valid && (code == fpu_pkg::RET_OK);

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      ret_en       <= 1'b0;
      ret          <= fpu_pkg::RET_OK;
    end else begin
      result_valid <= write_res;
      ret_en       <= valid;
      ret          <= code;
    end
  end

  // result holds until the next good op
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (write_res) begin
      result <= res_word;
    end
  end

endmodule

`default_nettype wire

//--- verilog/issue_stage.sv
// issue stage registering op and operands, checking parity and decoding the opcode
`default_nettype none
`timescale 1ns/1ps

module issue_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                en,
  input  fpu_pkg::opcode_t    op,
  input  fpu_pkg::bus_word_t  a_word,
  input  fpu_pkg::bus_word_t  b_word,
  output logic                valid,
  output fpu_pkg::data_t      a_data,
  output fpu_pkg::data_t      b_data,
  output logic                is_logic,
  output fpu_pkg::logic_sel_t logic_sel,
  output fpu_pkg::perm_sel_t  perm_sel,
  output fpu_pkg::ret_code_t  code
);

  fpu_pkg::opcode_t   op_q;
  fpu_pkg::bus_word_t a_q;
  fpu_pkg::bus_word_t b_q;
  logic               parity_err;
  logic               illegal;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= en;
    end
  end

  always_ff @(posedge clk) begin
    op_q <= op;
    a_q  <= a_word;
    b_q  <= b_word;
  end

  assign a_data = a_q[fpu_pkg::DATA_W-1:0];
  assign b_data = b_q[fpu_pkg::DATA_W-1:0];

  // even parity, a good word folds to zero
  assign parity_err = (^a_q) | (^b_q);

  always_comb begin
    is_logic  = 1'b0;
    logic_sel = fpu_pkg::LOGIC_AND;
    perm_sel  = fpu_pkg::PERM_COPY_A;
    illegal   = 1'b0;
    case (op_q)
      fpu_pkg::OP_AND:    is_logic = 1'b1;
      fpu_pkg::OP_OR: begin
        is_logic  = 1'b1;
        logic_sel = fpu_pkg::LOGIC_OR;
      end
      fpu_pkg::OP_XOR: begin
        is_logic  = 1'b1;
        logic_sel = fpu_pkg::LOGIC_XOR;
      end
      fpu_pkg::OP_ANDN: begin
        is_logic  = 1'b1;
        logic_sel = fpu_pkg::LOGIC_ANDN;
      end
      fpu_pkg::OP_COPY_A: perm_sel = fpu_pkg::PERM_COPY_A;
      fpu_pkg::OP_COPY_B: perm_sel = fpu_pkg::PERM_COPY_B;
      fpu_pkg::OP_SWAP_S: perm_sel = fpu_pkg::PERM_SWAP;
      fpu_pkg::OP_DUP_S:  perm_sel = fpu_pkg::PERM_DUP;
      default:            illegal  = 1'b1;
    endcase
  end

  // parity wins over an illegal opcode
  always_comb begin
    if (parity_err) begin
      code = fpu_pkg::RET_PARITY;
    end else if (illegal) begin
      code = fpu_pkg::RET_ILLEGAL;
    end else begin
      code = fpu_pkg::RET_OK;
    end
  end

endmodule

`default_nettype wire

//--- verilog/operand_forward.sv
// operand forwarding mux picking register-file, current bus or previous-cycle bus word
`default_nettype none
`timescale 1ns/1ps

module operand_forward (
  input  logic              clk,
  input  fpu_pkg::bus_word_t reg_word,
  input  logic              fwd,
  input  fpu_pkg::bus_idx_t bus_sel,
  input  logic              late,
  input  fpu_pkg::bus_word_t buses [fpu_pkg::BUS_COUNT],
  output fpu_pkg::bus_word_t operand
);

  fpu_pkg::bus_word_t bus_hist [fpu_pkg::BUS_COUNT];
  fpu_pkg::bus_word_t cur_word;
  fpu_pkg::bus_word_t old_word;

  // one-cycle copy of every bus, read only a cycle after it is written
  always_ff @(posedge clk) begin
    for (int i = 0; i < fpu_pkg::BUS_COUNT; i++) begin
      bus_hist[i] <= buses[i];
    end
  end

  always_comb begin
    cur_word = buses[bus_sel];
    old_word = bus_hist[bus_sel];
  end

  always_comb begin
    if (!fwd) begin
      operand = reg_word;
    end else if (late) begin
      // value the bus held at the previous edge
      operand = old_word;
    end else begin
      operand = cur_word;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fpu_pkg.sv
// fpu port package with data widths, bus word types and port encodings
`default_nettype none

package fpu_pkg;

  localparam int DATA_W    = 68;
  localparam int SINGLE_W  = 32;
  // bus 0 is the port's own result
  localparam int BUS_COUNT = 4;

  // low single 31..0, high single 63..32, class bits 67..64
  typedef logic [DATA_W-1:0] data_t;

  // top bit is even parity over the data
  typedef logic [DATA_W:0] bus_word_t;

  typedef logic [$clog2(BUS_COUNT)-1:0] bus_idx_t;

  // 8..15 reserved
  typedef enum logic [3:0] {
    OP_AND    = 4'd0,
    OP_OR     = 4'd1,
    OP_XOR    = 4'd2,
    OP_ANDN   = 4'd3,
    OP_COPY_A = 4'd4,
    OP_COPY_B = 4'd5,
    OP_SWAP_S = 4'd6,
    OP_DUP_S  = 4'd7
  } opcode_t;

  typedef enum logic [1:0] {
    LOGIC_AND,
    LOGIC_OR,
    LOGIC_XOR,
    LOGIC_ANDN
  } logic_sel_t;

  typedef enum logic [1:0] {
    PERM_COPY_A,
    PERM_COPY_B,
    PERM_SWAP,
    PERM_DUP
  } perm_sel_t;

  typedef enum logic [1:0] {
    RET_OK      = 2'd0,
    RET_PARITY  = 2'd1,
    RET_ILLEGAL = 2'd2
  } ret_code_t;

endpackage

`default_nettype wire
